//--- src/cshPkg.sv
// Shared widths, types and encodings; four ways assumed, way index sized from numWays
`default_nettype none

package cshPkg;

  localparam int numWays = 4;
  localparam int wayIdxW = $clog2(numWays);
  localparam int diagW = 8;

  typedef logic [numWays-1:0] wayVec_t;
  typedef logic [wayIdxW-1:0] wayIdx_t;
  typedef logic [1:0] diagSel_t;
  typedef logic [diagW-1:0] diagWord_t;

  typedef enum logic [1:0] {
    cycNone = 2'd0,
    cycMb   = 2'd1,
    cycChan = 2'd2,
    cycEbox = 2'd3
  } cycType_t;

  typedef enum logic [2:0] {
    seqIdle     = 3'd0,
    seqT0       = 3'd1,
    seqT1       = 3'd2,
    seqT2       = 3'd3,
    seqT3       = 3'd4,
    seqWaitCore = 3'd5
  } seqState_t;

  typedef enum logic [1:0] {
    outHit       = 2'd0,
    outCoreRead  = 2'd1,
    outWriteback = 2'd2,
    outBusyRetry = 2'd3
  } outcome_t;

  // Request levels, held until granted
  typedef struct packed {
    logic mb;
    logic chan;
    logic ebox;
  } cshReq_t;

  // Single-cycle grant strobes
  typedef struct packed {
    logic mb;
    logic chan;
    logic ebox;
  } cshGrant_t;

  typedef struct packed {
    wayVec_t validMatch;
    wayVec_t wordValid;
    wayVec_t written;
    wayIdx_t lru;
    logic cacheable;
    logic isWrite;
  } lookupInfo_t;

  typedef struct packed {
    logic valid;
    outcome_t outcome;
    wayIdx_t way;
  } eboxResp_t;

endpackage

`default_nettype wire

//--- src/cshArbiter.sv
// Fixed priority mb > chan > ebox; grants only while idle, requests must stay up until granted
`timescale 1ns/1ps
`default_nettype none

module cshArbiter (
  input  logic              clk,
  input  logic              rst,
  input  cshPkg::cshReq_t   req,
  input  logic              cycleDone,
  output cshPkg::cshGrant_t grant,
  output cshPkg::cycType_t  cycType,
  output logic              readyToGo
);

  cshPkg::cycType_t grantType;

  // Grant is combinational off the idle flag
  always_comb begin
    readyToGo = (cycType == cshPkg::cycNone);
    grant = '0;
    grantType = cshPkg::cycNone;
    if (readyToGo) begin
      if (req.mb) begin
        grant.mb = 1'b1;
        grantType = cshPkg::cycMb;
      end else if (req.chan) begin
        grant.chan = 1'b1;
        grantType = cshPkg::cycChan;
      end else if (req.ebox) begin
        grant.ebox = 1'b1;
        grantType = cshPkg::cycEbox;
      end
    end
  end

  // Cycle type held from the cycle after grant through cycleDone
  always_ff @(posedge clk) begin
    if (rst) begin
      cycType <= cshPkg::cycNone;
    end else if (cycleDone) begin
      cycType <= cshPkg::cycNone;
    end else if (readyToGo) begin
      cycType <= grantType;
    end
  end

endmodule

`default_nettype wire

//--- src/cshSequencer.sv
// T0-T3 cycle timing; abort sampled in T1 only, core read wait ends on the first coreDataValid
`timescale 1ns/1ps
`default_nettype none

module cshSequencer (
  input  logic              clk,
  input  logic              rst,
  input  cshPkg::cshGrant_t grant,
  input  cshPkg::cycType_t  cycType,
  input  logic              eboxCycAbort,
  input  logic              coreDataValid,
  input  cshPkg::outcome_t  outcome,
  input  cshPkg::wayIdx_t   way,
  output logic              evalStrobe,
  output logic              cycleDone,
  output cshPkg::seqState_t state,
  output logic              coreReadReq,
  output cshPkg::eboxResp_t eboxResp
);

  cshPkg::seqState_t nextState;
  logic isEbox;

  always_comb begin
    isEbox = (cycType == cshPkg::cycEbox);
    nextState = state;
    evalStrobe = 1'b0;
    cycleDone = 1'b0;
    eboxResp.valid = 1'b0;
    eboxResp.outcome = outcome;
    eboxResp.way = way;

    case (state)
      cshPkg::seqIdle: begin
        if (|grant) begin
          nextState = cshPkg::seqT0;
        end
      end
      cshPkg::seqT0: begin
        nextState = cshPkg::seqT1;
      end
      cshPkg::seqT1: begin
        // Aborted EBOX cycle ends here with no response
        if (isEbox && eboxCycAbort) begin
          cycleDone = 1'b1;
          nextState = cshPkg::seqIdle;
        end else begin
          nextState = cshPkg::seqT2;
        end
      end
      cshPkg::seqT2: begin
        evalStrobe = 1'b1;
        nextState = cshPkg::seqT3;
      end
      cshPkg::seqT3: begin
        if (isEbox && outcome == cshPkg::outCoreRead) begin
          nextState = cshPkg::seqWaitCore;
        end else begin
          cycleDone = 1'b1;
          eboxResp.valid = isEbox;
          nextState = cshPkg::seqIdle;
        end
      end
      cshPkg::seqWaitCore: begin
        // Request dropped means core data arrived last cycle
        if (!coreReadReq) begin
          cycleDone = 1'b1;
          eboxResp.valid = 1'b1;
          nextState = cshPkg::seqIdle;
        end
      end
      default: begin
        nextState = cshPkg::seqIdle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= cshPkg::seqIdle;
    end else begin
      state <= nextState;
    end
  end

  // Core read request, up from T3 exit until coreDataValid
  always_ff @(posedge clk) begin
    if (rst) begin
      coreReadReq <= 1'b0;
    end else if (state == cshPkg::seqT3 && nextState == cshPkg::seqWaitCore) begin
      coreReadReq <= 1'b1;
    end else if (coreDataValid) begin
      coreReadReq <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- src/cshLookup.sv
// Directory lookup decision; inputs must be stable during evalStrobe, result held until the next one
`timescale 1ns/1ps
`default_nettype none

module cshLookup (
  input  logic                clk,
  input  logic                rst,
  input  logic                evalStrobe,
  input  cshPkg::lookupInfo_t lookup,
  input  logic                coreBusy,
  output cshPkg::outcome_t    outcome,
  output cshPkg::wayIdx_t     way
);

  cshPkg::wayVec_t hitVec;
  logic lruWritten;
  cshPkg::outcome_t nextOutcome;
  cshPkg::wayIdx_t nextWay;

  // Highest-numbered set bit wins
  function automatic cshPkg::wayIdx_t topWay(input cshPkg::wayVec_t vec);
    cshPkg::wayIdx_t idx;
    idx = '0;
    for (int i = 0; i < cshPkg::numWays; i++) begin
      if (vec[i]) begin
        idx = cshPkg::wayIdx_t'(i);
      end
    end
    return idx;
  endfunction

  always_comb begin
    // Writes only need the tag, reads also need the word
    if (lookup.isWrite) begin
      hitVec = lookup.validMatch;
    end else begin
      hitVec = lookup.validMatch & lookup.wordValid;
    end
    lruWritten = lookup.written[lookup.lru];
    nextWay = lookup.lru;

    if (|hitVec) begin
      nextOutcome = cshPkg::outHit;
      nextWay = topWay(hitVec);
    end else if (coreBusy) begin
      nextOutcome = cshPkg::outBusyRetry;
    end else if (lookup.cacheable && lruWritten) begin
      nextOutcome = cshPkg::outWriteback;
    end else begin
      nextOutcome = cshPkg::outCoreRead;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      outcome <= cshPkg::outHit;
      way <= '0;
    end else if (evalStrobe) begin
      outcome <= nextOutcome;
      way <= nextWay;
    end
  end

endmodule

`default_nettype wire

//--- src/cshDiag.sv
// Diagnostic word valid the cycle after diagEn; reads as zero whenever diagEn was low
`timescale 1ns/1ps
`default_nettype none

module cshDiag (
  input  logic              clk,
  input  logic              rst,
  input  logic              diagEn,
  input  cshPkg::diagSel_t  diagSel,
  input  cshPkg::seqState_t state,
  input  cshPkg::cycType_t  cycType,
  input  logic              readyToGo,
  input  logic              coreReadReq,
  input  cshPkg::outcome_t  outcome,
  input  cshPkg::wayIdx_t   way,
  output cshPkg::diagWord_t diagData
);

  cshPkg::diagWord_t groupWord;

  // Right-justified groups, upper bits zero
  always_comb begin
    case (diagSel)
      2'd0: groupWord = cshPkg::diagWord_t'(state);
      2'd1: groupWord = cshPkg::diagWord_t'({readyToGo, cycType});
      2'd2: groupWord = cshPkg::diagWord_t'({outcome, way});
      default: groupWord = cshPkg::diagWord_t'(coreReadReq);
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst || !diagEn) begin
      diagData <= '0;
    end else begin
      diagData <= groupWord;
    end
  end

endmodule

`default_nettype wire

//--- src/cshTop.sv
// Sweeper control core top; no back-pressure, lookup inputs must hold from grant to cycle end
`timescale 1ns/1ps
`default_nettype none

module cshTop (
  input  logic                clk,
  input  logic                rst,
  input  cshPkg::cshReq_t     req,
  input  cshPkg::lookupInfo_t lookup,
  input  logic                eboxCycAbort,
  input  logic                coreBusy,
  input  logic                coreDataValid,
  input  logic                diagEn,
  input  cshPkg::diagSel_t    diagSel,
  output cshPkg::cshGrant_t   grant,
  output cshPkg::cycType_t    cycType,
  output logic                readyToGo,
  output cshPkg::eboxResp_t   eboxResp,
  output logic                coreReadReq,
  output cshPkg::diagWord_t   diagData
);

  logic cycleDone;
  logic evalStrobe;
  cshPkg::seqState_t state;
  cshPkg::outcome_t outcome;
  cshPkg::wayIdx_t way;

  cshArbiter arbiter (
    .clk(clk), .rst(rst), .req(req), .cycleDone(cycleDone),
    .grant(grant), .cycType(cycType), .readyToGo(readyToGo)
  );

  cshSequencer sequencer (
    .clk(clk), .rst(rst), .grant(grant), .cycType(cycType),
    .eboxCycAbort(eboxCycAbort), .coreDataValid(coreDataValid),
    .outcome(outcome), .way(way), .evalStrobe(evalStrobe),
    .cycleDone(cycleDone), .state(state), .coreReadReq(coreReadReq),
    .eboxResp(eboxResp)
  );

  cshLookup lookupUnit (
    .clk(clk), .rst(rst), .evalStrobe(evalStrobe), .lookup(lookup),
    .coreBusy(coreBusy), .outcome(outcome), .way(way)
  );

  // Diagnostic readout
  cshDiag diag (
    .clk(clk), .rst(rst), .diagEn(diagEn), .diagSel(diagSel),
    .state(state), .cycType(cycType), .readyToGo(readyToGo),
    .coreReadReq(coreReadReq), .outcome(outcome), .way(way),
    .diagData(diagData)
  );

endmodule

`default_nettype wire

//--- test/cshChecker.sv
// Cycle model of the control core; samples every port on the rising edge, inputs move on the falling one
`timescale 1ns/1ps
`default_nettype none

module cshChecker (
  input  logic                clk,
  input  logic                rst,
  input  cshPkg::cshReq_t     req,
  input  cshPkg::lookupInfo_t lookup,
  input  logic                eboxCycAbort,
  input  logic                coreBusy,
  input  logic                coreDataValid,
  input  logic                diagEn,
  input  cshPkg::diagSel_t    diagSel,
  input  cshPkg::cshGrant_t   grant,
  input  cshPkg::cycType_t    cycType,
  input  logic                readyToGo,
  input  cshPkg::eboxResp_t   eboxResp,
  input  logic                coreReadReq,
  input  cshPkg::diagWord_t   diagData,
  output int                  errorCount,
  output int                  checkCount
);

  int errors = 0;
  int checks = 0;
  logic rstPrev = 1'b0;
  logic busy;
  logic waitCore;
  logic coreSeen;
  int phase;
  cshPkg::cycType_t curType;
  cshPkg::outcome_t heldOutcome;
  cshPkg::wayIdx_t heldWay;
  cshPkg::diagWord_t expDiag;

  assign errorCount = errors;
  assign checkCount = checks;

  task automatic compareValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error %s: got %h, expected %h at %0t ns", name, got, exp, $time);
    end
  endtask

  // Hit on the highest matching way, otherwise retry, writeback or core read on the LRU way
  task automatic evaluateLookup(input cshPkg::lookupInfo_t lk, input logic busyIn,
                                output cshPkg::outcome_t res, output cshPkg::wayIdx_t w);
    logic anyHit;
    int i;
    anyHit = 1'b0;
    w = lk.lru;
    for (i = 0; i < cshPkg::numWays; i++) begin
      if (lk.validMatch[i] && (lk.isWrite || lk.wordValid[i])) begin
        anyHit = 1'b1;
        w = cshPkg::wayIdx_t'(i);
      end
    end
    if (anyHit) res = cshPkg::outHit;
    else if (busyIn) res = cshPkg::outBusyRetry;
    else if (lk.cacheable && lk.written[lk.lru]) res = cshPkg::outWriteback;
    else res = cshPkg::outCoreRead;
  endtask

  function automatic cshPkg::diagWord_t packDiag(input cshPkg::diagSel_t sel,
      input cshPkg::seqState_t st, input logic ready, input cshPkg::cycType_t ct,
      input logic coreReq, input cshPkg::outcome_t oc, input cshPkg::wayIdx_t w);
    cshPkg::diagWord_t word;
    word = '0;
    case (sel)
      2'd0: word[2:0] = st;
      2'd1: word[2:0] = {ready, ct};
      2'd2: word[3:0] = {oc, w};
      default: word[0] = coreReq;
    endcase
    return word;
  endfunction

  always @(posedge clk) begin : model
    cshPkg::cshGrant_t expGrant;
    cshPkg::seqState_t expState;
    logic expValid;
    logic expCoreReq;
    logic done;
    if (rst) begin
      if (rstPrev) begin
        compareValue("grant", grant, 3'b000);
        compareValue("cycType", cycType, cshPkg::cycNone);
        compareValue("readyToGo", readyToGo, 1'b1);
        compareValue("eboxResp.valid", eboxResp.valid, 1'b0);
        compareValue("coreReadReq", coreReadReq, 1'b0);
        compareValue("diagData", diagData, 8'h00);
      end
      busy = 1'b0;
      waitCore = 1'b0;
      coreSeen = 1'b0;
      phase = 0;
      curType = cshPkg::cycNone;
      heldOutcome = cshPkg::outHit;
      heldWay = '0;
      expDiag = '0;
    end else begin
      expGrant = '0;
      expValid = 1'b0;
      expCoreReq = waitCore;
      done = 1'b0;
      expState = cshPkg::seqWaitCore;
      if (!busy) expState = cshPkg::seqIdle;
      else if (phase < 5) expState = cshPkg::seqState_t'(phase);
      if (!busy) begin
        if (req.mb) expGrant.mb = 1'b1;
        else if (req.chan) expGrant.chan = 1'b1;
        else if (req.ebox) expGrant.ebox = 1'b1;
      end
      // Abort ends in g+2, plain responses in g+4, core reads one cycle after the data
      if (busy && phase == 2 && curType == cshPkg::cycEbox && eboxCycAbort) done = 1'b1;
      if (busy && phase == 4 &&
          (curType != cshPkg::cycEbox || heldOutcome != cshPkg::outCoreRead)) begin
        done = 1'b1;
        expValid = (curType == cshPkg::cycEbox);
      end
      if (coreSeen) begin
        done = 1'b1;
        expValid = 1'b1;
      end
      compareValue("grant", grant, expGrant);
      compareValue("readyToGo", readyToGo, !busy);
      compareValue("cycType", cycType, busy ? curType : cshPkg::cycNone);
      compareValue("coreReadReq", coreReadReq, expCoreReq);
      compareValue("diagData", diagData, expDiag);
      compareValue("eboxResp.valid", eboxResp.valid, expValid);
      if (expValid) begin
        compareValue("eboxResp.outcome", eboxResp.outcome,
                     coreSeen ? cshPkg::outCoreRead : heldOutcome);
        compareValue("eboxResp.way", eboxResp.way, heldWay);
      end
      expDiag = '0;
      if (diagEn) begin
        expDiag = packDiag(diagSel, expState, !busy, busy ? curType : cshPkg::cycNone,
                           expCoreReq, heldOutcome, heldWay);
      end
      if (busy && phase == 3) evaluateLookup(lookup, coreBusy, heldOutcome, heldWay);
      if (waitCore && coreDataValid) begin
        waitCore = 1'b0;
        coreSeen = 1'b1;
      end
      if (busy && phase == 4 && !done) waitCore = 1'b1;
      if (done) begin
        busy = 1'b0;
        coreSeen = 1'b0;
        phase = 0;
      end else if (busy) begin
        phase++;
      end else if (expGrant != '0) begin
        busy = 1'b1;
        phase = 1;
        if (expGrant.mb) curType = cshPkg::cycMb;
        else if (expGrant.chan) curType = cshPkg::cycChan;
        else curType = cshPkg::cycEbox;
      end
    end
    rstPrev = rst;
  end

endmodule

`default_nettype wire

//--- test/cshTb.sv
// Random stimulus from a fixed xorshift seed; run length and watchdog both scale with numTrans
`timescale 1ns/1ps
`default_nettype none

module cshTb;

  localparam int clkPeriod = 20;
  localparam int rstCycles = 8;
  localparam int numTrans = 300;

  logic clk;
  logic rst;
  cshPkg::cshReq_t req;
  cshPkg::lookupInfo_t lookup;
  logic eboxCycAbort;
  logic coreBusy;
  logic coreDataValid;
  logic diagEn;
  cshPkg::diagSel_t diagSel;
  cshPkg::cshGrant_t grant;
  cshPkg::cycType_t cycType;
  logic readyToGo;
  cshPkg::eboxResp_t eboxResp;
  logic coreReadReq;
  cshPkg::diagWord_t diagData;
  int errorCount;
  int checkCount;
  logic [31:0] rngState;
  cshPkg::cshGrant_t seenGrant;
  int grantCount;
  int coreWait;

  cshTop DUT (
    .clk(clk), .rst(rst), .req(req), .lookup(lookup), .eboxCycAbort(eboxCycAbort),
    .coreBusy(coreBusy), .coreDataValid(coreDataValid), .diagEn(diagEn), .diagSel(diagSel),
    .grant(grant), .cycType(cycType), .readyToGo(readyToGo), .eboxResp(eboxResp),
    .coreReadReq(coreReadReq), .diagData(diagData)
  );

  cshChecker portCheck (
    .clk(clk), .rst(rst), .req(req), .lookup(lookup), .eboxCycAbort(eboxCycAbort),
    .coreBusy(coreBusy), .coreDataValid(coreDataValid), .diagEn(diagEn), .diagSel(diagSel),
    .grant(grant), .cycType(cycType), .readyToGo(readyToGo), .eboxResp(eboxResp),
    .coreReadReq(coreReadReq), .diagData(diagData), .errorCount(errorCount),
    .checkCount(checkCount)
  );

  function automatic logic [31:0] nextRandom(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Falling-edge stimulus; lookup data only changes while the controller is idle
  task automatic driveInputs();
    logic [31:0] r0;
    logic [31:0] r1;
    rngState = nextRandom(rngState);
    r0 = rngState;
    rngState = nextRandom(rngState);
    r1 = rngState;
    if (seenGrant.mb) req.mb = 1'b0;
    if (seenGrant.chan) req.chan = 1'b0;
    if (seenGrant.ebox) req.ebox = 1'b0;
    if (grantCount < numTrans) begin
      req.mb = req.mb | (r0[2:0] == 3'd0);
      req.chan = req.chan | (r0[5:3] == 3'd0);
      req.ebox = req.ebox | r0[6];
    end
    if (readyToGo) begin
      lookup.validMatch = r1[3:0] & r1[7:4];
      lookup.wordValid = r1[11:8];
      lookup.written = r1[15:12];
      lookup.lru = r1[17:16];
      lookup.cacheable = r1[18];
      lookup.isWrite = r1[19];
    end
    coreBusy = r1[20] & r1[21];
    eboxCycAbort = (r1[24:22] == 3'd0);
    diagEn = r1[25];
    diagSel = r1[27:26];
    // Core data 1 to 8 cycles after coreReadReq rises
    coreDataValid = 1'b0;
    if (coreReadReq) begin
      if (coreWait == 0) coreWait = 2 + int'(r0[10:8]);
      coreWait--;
      coreDataValid = (coreWait == 0);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #(clkPeriod / 2) clk = ~clk;
    end
  end

  initial begin
    rst = 1'b1;
    req = '0;
    lookup = '0;
    eboxCycAbort = 1'b0;
    coreBusy = 1'b0;
    coreDataValid = 1'b0;
    diagEn = 1'b0;
    diagSel = '0;
    rngState = 32'h5c5d_5c7a;
    seenGrant = '0;
    grantCount = 0;
    coreWait = 0;
    repeat (rstCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    while (grantCount < numTrans || req != '0 || !readyToGo) begin
      @(posedge clk);
      seenGrant = grant;
      if (seenGrant != '0) grantCount++;
      @(negedge clk);
      driveInputs();
    end
    repeat (3) @(posedge clk);
    $display("Closing: %0d grants, %0d checks, %0d errors", grantCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Up to 16 cycles per transaction
  initial begin
    #((rstCycles + numTrans * 16) * clkPeriod);
    $display("Watchdog timeout: the run did not end within %0d cycles", rstCycles + numTrans * 16);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
src/cshPkg.sv
src/cshArbiter.sv
src/cshSequencer.sv
src/cshLookup.sv
src/cshDiag.sv
src/cshTop.sv
test/cshChecker.sv
test/cshTb.sv
